/* cpu_bus_macros.svh */
`ifndef CPU_BUS_MACROS_SVH
`define CPU_BUS_MACROS_SVH

// Bus widths
`define CPU_ADDR_W   16
`define VBUS_ADDR_W  13
`define DATA_W       8

// Credit depths
`define CPU_CREDITS  2
`define VBUS_CREDITS 4

// Main CPU map, first and last address of each region
`define MAIN_SCROLL0_BASE    16'h0000
`define MAIN_SCROLL0_LIMIT   16'h1FFF
`define MAIN_SCROLL1_BASE    16'h2000
`define MAIN_SCROLL1_LIMIT   16'h3FFF
`define MAIN_OBJECT_BASE     16'h4000
`define MAIN_OBJECT_LIMIT    16'h5FFF
`define MAIN_LATCH0_BASE     16'h8000
`define MAIN_LATCH0_LIMIT    16'h81FF
`define MAIN_LATCH1_BASE     16'h8200
`define MAIN_LATCH1_LIMIT    16'h83FF
`define MAIN_BACKCOLOR_BASE  16'h8400
`define MAIN_BACKCOLOR_LIMIT 16'h85FF

// Sub CPU map, no back color window
`define SUB_OBJECT_BASE      16'h0000
`define SUB_OBJECT_LIMIT     16'h1FFF
`define SUB_SCROLL0_BASE     16'h2000
`define SUB_SCROLL0_LIMIT    16'h3FFF
`define SUB_SCROLL1_BASE     16'h4000
`define SUB_SCROLL1_LIMIT    16'h5FFF
`define SUB_LATCH0_BASE      16'h6000
`define SUB_LATCH0_LIMIT     16'h61FF
`define SUB_LATCH1_BASE      16'h6200
`define SUB_LATCH1_LIMIT     16'h63FF

`endif

/* cpu_bus_pkg.sv */
`include "cpu_bus_macros.svh"

package cpu_bus_pkg;

	// Full CPU address
	typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t;

	// Offset inside one video region
	typedef logic [`VBUS_ADDR_W-1:0] vbus_addr_t;

	// Write data byte
	typedef logic [`DATA_W-1:0] cpu_data_t;

	////////////////////////////////////////////////////////////
	// Region strobes on the shared video bus
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		REGION_SCROLL0   = 3'd0,
		REGION_SCROLL1   = 3'd1,
		REGION_OBJECT    = 3'd2,
		REGION_LATCH0    = 3'd3,
		REGION_LATCH1    = 3'd4,
		REGION_BACKCOLOR = 3'd5
	} vbus_region_e;

	// Which CPU owns the current bus slot
	typedef enum logic {
		SLOT_MAIN = 1'b0,
		SLOT_SUB  = 1'b1
	} slot_state_e;

endpackage

/* cpu_bus_if.sv */
`timescale 1ns/1ps

// One decoded write from a decoder buffer head to the arbiter
interface cpu_bus_if
	import cpu_bus_pkg::*;
();

	logic         req;
	vbus_region_e region;
	vbus_addr_t   offset;
	cpu_data_t    data;
	logic         grant;

	// Decoder side, head of its write buffer
	modport dec (
		output req,
		output region,
		output offset,
		output data,
		input  grant
	);

	// Arbiter side, req and grant together pop the head
	modport arb (
		input  req,
		input  region,
		input  offset,
		input  data,
		output grant
	);

endinterface

/* main_decoder.sv */
`timescale 1ns/1ps

`include "cpu_bus_macros.svh"

module main_decoder
	import cpu_bus_pkg::*;
(
	input  logic      clk_6m,
	input  logic      arst_n,
	input  logic      cpu_valid,
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_data,
	output logic      cpu_credit,
	cpu_bus_if.dec    bus
);

	localparam int DEPTH = `CPU_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	vbus_region_e     dec_region;
	logic             dec_fwd;
	vbus_region_e     buf_region [DEPTH];
	vbus_addr_t       buf_offset [DEPTH];
	cpu_data_t        buf_data [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;
	logic             drop;
	logic             credit_pend;

	////////////////////////////////////////////////////////////
	// Main CPU address map
	////////////////////////////////////////////////////////////

	always_comb begin
		dec_fwd    = 1'b1;
		dec_region = REGION_SCROLL0;
		if (cpu_addr >= `MAIN_SCROLL0_BASE && cpu_addr <= `MAIN_SCROLL0_LIMIT) begin
			dec_region = REGION_SCROLL0;
		end else if (cpu_addr >= `MAIN_SCROLL1_BASE && cpu_addr <= `MAIN_SCROLL1_LIMIT) begin
			dec_region = REGION_SCROLL1;
		end else if (cpu_addr >= `MAIN_OBJECT_BASE && cpu_addr <= `MAIN_OBJECT_LIMIT) begin
			dec_region = REGION_OBJECT;
		end else if (cpu_addr >= `MAIN_LATCH0_BASE && cpu_addr <= `MAIN_LATCH0_LIMIT) begin
			dec_region = REGION_LATCH0;
		end else if (cpu_addr >= `MAIN_LATCH1_BASE && cpu_addr <= `MAIN_LATCH1_LIMIT) begin
			dec_region = REGION_LATCH1;
		end else if (cpu_addr >= `MAIN_BACKCOLOR_BASE &&
				cpu_addr <= `MAIN_BACKCOLOR_LIMIT) begin
			dec_region = REGION_BACKCOLOR;
		end else begin
			// ROM and other CPU-local space
			dec_fwd = 1'b0;
		end
	end

	assign push = cpu_valid && dec_fwd;
	assign drop = cpu_valid && !dec_fwd;
	assign pop  = bus.req && bus.grant;

	////////////////////////////////////////////////////////////
	// Write buffer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk_6m) begin
		if (push) begin
			buf_region[wr_ptr] <= dec_region;
			buf_offset[wr_ptr] <= cpu_addr[`VBUS_ADDR_W-1:0];
			buf_data[wr_ptr]   <= cpu_data;
		end
	end

	assign bus.req    = (count != '0);
	assign bus.region = buf_region[rd_ptr];
	assign bus.offset = buf_offset[rd_ptr];
	assign bus.data   = buf_data[rd_ptr];

	// Credit return, a pop that meets a drop is held back one cycle
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			cpu_credit  <= 1'b0;
			credit_pend <= 1'b0;
		end else begin
			cpu_credit  <= pop || drop || credit_pend;
			credit_pend <= (pop && drop) || (credit_pend && (pop || drop));
		end
	end

endmodule

/* sub_decoder.sv */
`timescale 1ns/1ps

`include "cpu_bus_macros.svh"

module sub_decoder
	import cpu_bus_pkg::*;
(
	input  logic      clk_6m,
	input  logic      arst_n,
	input  logic      cpu_valid,
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_data,
	output logic      cpu_credit,
	cpu_bus_if.dec    bus
);

	localparam int DEPTH = `CPU_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	vbus_region_e     dec_region;
	logic             dec_fwd;
	vbus_region_e     buf_region [DEPTH];
	vbus_addr_t       buf_offset [DEPTH];
	cpu_data_t        buf_data [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;
	logic             drop;
	logic             credit_pend;

	////////////////////////////////////////////////////////////
	// Sub CPU address map
	////////////////////////////////////////////////////////////

	// Object RAM sits at the bottom here, back color is never decoded
	always_comb begin
		dec_fwd    = 1'b1;
		dec_region = REGION_OBJECT;
		if (cpu_addr >= `SUB_OBJECT_BASE && cpu_addr <= `SUB_OBJECT_LIMIT) begin
			dec_region = REGION_OBJECT;
		end else if (cpu_addr >= `SUB_SCROLL0_BASE && cpu_addr <= `SUB_SCROLL0_LIMIT) begin
			dec_region = REGION_SCROLL0;
		end else if (cpu_addr >= `SUB_SCROLL1_BASE && cpu_addr <= `SUB_SCROLL1_LIMIT) begin
			dec_region = REGION_SCROLL1;
		end else if (cpu_addr >= `SUB_LATCH0_BASE && cpu_addr <= `SUB_LATCH0_LIMIT) begin
			dec_region = REGION_LATCH0;
		end else if (cpu_addr >= `SUB_LATCH1_BASE && cpu_addr <= `SUB_LATCH1_LIMIT) begin
			dec_region = REGION_LATCH1;
		end else begin
			dec_fwd = 1'b0;
		end
	end

	assign push = cpu_valid && dec_fwd;
	assign drop = cpu_valid && !dec_fwd;
	assign pop  = bus.req && bus.grant;

	// Buffer pointers and fill level
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk_6m) begin
		if (push) begin
			buf_region[wr_ptr] <= dec_region;
			buf_offset[wr_ptr] <= cpu_addr[`VBUS_ADDR_W-1:0];
			buf_data[wr_ptr]   <= cpu_data;
		end
	end

	assign bus.req    = (count != '0);
	assign bus.region = buf_region[rd_ptr];
	assign bus.offset = buf_offset[rd_ptr];
	assign bus.data   = buf_data[rd_ptr];

	// Drop credit goes out at once, a clashing pop credit waits one cycle
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			cpu_credit  <= 1'b0;
			credit_pend <= 1'b0;
		end else begin
			cpu_credit  <= pop || drop || credit_pend;
			credit_pend <= (pop && drop) || (credit_pend && (pop || drop));
		end
	end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/1ps

`include "cpu_bus_macros.svh"

module bus_arbiter
	import cpu_bus_pkg::*;
(
	input  logic         clk_6m,
	input  logic         arst_n,
	cpu_bus_if.arb       main_bus,
	cpu_bus_if.arb       sub_bus,
	input  logic         vbus_credit,
	output logic         vbus_valid,
	output vbus_region_e vbus_region,
	output vbus_addr_t   vbus_addr,
	output cpu_data_t    vbus_data,
	output logic         vbus_master
);

	localparam int CNT_W = $clog2(`VBUS_CREDITS + 1);

	slot_state_e      slot;
	logic [CNT_W-1:0] credit_cnt;
	logic             credit_ok;
	logic             grant_main;
	logic             grant_sub;
	logic             grant_any;

	////////////////////////////////////////////////////////////
	// Slot selection
	////////////////////////////////////////////////////////////

	// The write now on the bus still holds one credit
	assign credit_ok = credit_cnt > CNT_W'(vbus_valid);

	// Slot owner first, the other side may use an idle slot
	assign grant_main = credit_ok && main_bus.req && (slot == SLOT_MAIN || !sub_bus.req);
	assign grant_sub  = credit_ok && sub_bus.req && (slot == SLOT_SUB || !main_bus.req);
	assign grant_any  = grant_main || grant_sub;

	assign main_bus.grant = grant_main;
	assign sub_bus.grant  = grant_sub;

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			slot <= SLOT_MAIN;
		end else if (grant_any) begin
			slot <= (slot == SLOT_MAIN) ? SLOT_SUB : SLOT_MAIN;
		end
	end

	////////////////////////////////////////////////////////////
	// Downstream credits and video bus registers
	////////////////////////////////////////////////////////////

	// One credit spent per issued write, one back per vbus_credit pulse
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			credit_cnt <= CNT_W'(`VBUS_CREDITS);
		end else begin
			credit_cnt <= credit_cnt - CNT_W'(vbus_valid) + CNT_W'(vbus_credit);
		end
	end

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			vbus_valid <= 1'b0;
		end else begin
			vbus_valid <= grant_any;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (grant_main) begin
			vbus_region <= main_bus.region;
			vbus_addr   <= main_bus.offset;
			vbus_data   <= main_bus.data;
			vbus_master <= 1'b0;
		end else if (grant_sub) begin
			vbus_region <= sub_bus.region;
			vbus_addr   <= sub_bus.offset;
			vbus_data   <= sub_bus.data;
			vbus_master <= 1'b1;
		end
	end

endmodule

/* cpu_subsystem.sv */
`timescale 1ns/1ps

module cpu_subsystem
	import cpu_bus_pkg::*;
(
	input  logic         clk_6m,
	input  logic         arst_n,
	// Main CPU write port
	input  logic         main_valid,
	input  cpu_addr_t    main_addr,
	input  cpu_data_t    main_data,
	output logic         main_credit,
	// Sub CPU write port
	input  logic         sub_valid,
	input  cpu_addr_t    sub_addr,
	input  cpu_data_t    sub_data,
	output logic         sub_credit,
	// Shared video register bus
	input  logic         vbus_credit,
	output logic         vbus_valid,
	output vbus_region_e vbus_region,
	output vbus_addr_t   vbus_addr,
	output cpu_data_t    vbus_data,
	output logic         vbus_master
);

	// Decoded write channels into the arbiter
	cpu_bus_if main_bus ();
	cpu_bus_if sub_bus ();

	main_decoder u_main_dec (
		.clk_6m     (clk_6m),
		.arst_n     (arst_n),
		.cpu_valid  (main_valid),
		.cpu_addr   (main_addr),
		.cpu_data   (main_data),
		.cpu_credit (main_credit),
		.bus        (main_bus.dec)
	);

	sub_decoder u_sub_dec (
		.clk_6m     (clk_6m),
		.arst_n     (arst_n),
		.cpu_valid  (sub_valid),
		.cpu_addr   (sub_addr),
		.cpu_data   (sub_data),
		.cpu_credit (sub_credit),
		.bus        (sub_bus.dec)
	);

	bus_arbiter u_arb (
		.clk_6m      (clk_6m),
		.arst_n      (arst_n),
		.main_bus    (main_bus.arb),
		.sub_bus     (sub_bus.arb),
		.vbus_credit (vbus_credit),
		.vbus_valid  (vbus_valid),
		.vbus_region (vbus_region),
		.vbus_addr   (vbus_addr),
		.vbus_data   (vbus_data),
		.vbus_master (vbus_master)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

// 100 ns clock with reset held low for the first 5 rising edges
module tb_clock_gen (
	output logic clk_6m,
	output logic arst_n
);

	initial begin
		clk_6m = 1'b0;
		forever #50 clk_6m = ~clk_6m;
	end

	initial begin
		arst_n <= 1'b0;
		repeat (5) @(posedge clk_6m);
		arst_n <= 1'b1;
	end

endmodule

/* cpu_subsystem_checker.sv */
`timescale 1ns/1ps

`include "cpu_bus_macros.svh"

module cpu_subsystem_checker
	import cpu_bus_pkg::*;
(
	input logic         clk_6m,
	input logic         arst_n,
	input logic         main_valid,
	input cpu_addr_t    main_addr,
	input logic         main_credit,
	input logic         sub_valid,
	input cpu_addr_t    sub_addr,
	input logic         sub_credit,
	input logic         vbus_credit,
	input logic         vbus_valid,
	input vbus_region_e vbus_region,
	input logic         vbus_master
);

	int unsigned fail_count = 0;
	int          main_cnt;
	int          sub_cnt;
	int          vbus_cnt;
	logic        main_local;
	logic        sub_local;

	// Addresses outside every video window of each map
	assign main_local = !(main_addr <= `MAIN_OBJECT_LIMIT ||
		(main_addr >= `MAIN_LATCH0_BASE && main_addr <= `MAIN_BACKCOLOR_LIMIT));
	assign sub_local = sub_addr > `SUB_LATCH1_LIMIT;

	// Credit counts as seen from both ends of each link
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			main_cnt <= `CPU_CREDITS;
			sub_cnt  <= `CPU_CREDITS;
			vbus_cnt <= `VBUS_CREDITS;
		end else begin
			main_cnt <= main_cnt - int'(main_valid) + int'(main_credit);
			sub_cnt  <= sub_cnt - int'(sub_valid) + int'(sub_credit);
			vbus_cnt <= vbus_cnt - int'(vbus_valid) + int'(vbus_credit);
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk_6m)
		(!arst_n || $rose(arst_n)) |-> (!vbus_valid && !main_credit && !sub_credit))
		else begin
			fail_count++;
			$error("video bus or CPU credit active during or just after reset");
		end

	cpu_credit_range: assert property (@(posedge clk_6m) disable iff (!arst_n)
		main_cnt >= 0 && main_cnt <= `CPU_CREDITS &&
		sub_cnt >= 0 && sub_cnt <= `CPU_CREDITS)
		else begin
			fail_count++;
			$error("CPU credit count out of range, main %0d sub %0d", main_cnt, sub_cnt);
		end

	vbus_needs_credit: assert property (@(posedge clk_6m) disable iff (!arst_n)
		vbus_valid |-> (vbus_cnt > 0 && vbus_cnt <= `VBUS_CREDITS))
		else begin
			fail_count++;
			$error("video bus write issued with %0d downstream credits", vbus_cnt);
		end

	main_drop_credit: assert property (@(posedge clk_6m) disable iff (!arst_n)
		(main_valid && main_local) |=> main_credit)
		else begin
			fail_count++;
			$error("no main credit in the cycle after a local write");
		end

	sub_drop_credit: assert property (@(posedge clk_6m) disable iff (!arst_n)
		(sub_valid && sub_local) |=> sub_credit)
		else begin
			fail_count++;
			$error("no sub credit in the cycle after a local write");
		end

	// Back color is a main-only window
	sub_no_backcolor: assert property (@(posedge clk_6m) disable iff (!arst_n)
		(vbus_valid && vbus_master) |-> vbus_region != REGION_BACKCOLOR)
		else begin
			fail_count++;
			$error("sub CPU write reached back color");
		end

endmodule

/* tb_cpu_subsystem.sv */
`timescale 1ns/1ps

`include "cpu_bus_macros.svh"

module tb_cpu_subsystem
	import cpu_bus_pkg::*;
();

	logic         clk_6m;
	logic         arst_n;
	logic         main_valid;
	cpu_addr_t    main_addr;
	cpu_data_t    main_data;
	logic         main_credit;
	logic         sub_valid;
	cpu_addr_t    sub_addr;
	cpu_data_t    sub_data;
	logic         sub_credit;
	logic         vbus_credit;
	logic         vbus_valid;
	vbus_region_e vbus_region;
	vbus_addr_t   vbus_addr;
	cpu_data_t    vbus_data;
	logic         vbus_master;

	integer      seed = 32'haca82839;
	int          errors = 0;
	int          timeouts = 0;
	int          tests_done = 0;
	int          checked = 0;
	int          main_cnt = `CPU_CREDITS;
	int          sub_cnt = `CPU_CREDITS;
	int          ds_owed = 0;
	logic        ds_stall = 1'b0;
	logic        ds_fast = 1'b0;
	// Pending CPU writes as {addr, data}
	logic [23:0] main_todo[$];
	logic [23:0] sub_todo[$];
	// Expected bus writes as {region, offset, data}
	logic [23:0] main_exp[$];
	logic [23:0] sub_exp[$];
	logic        issue_log[$];
	time         issue_time[$];
	logic [23:0] main_word;
	logic [23:0] sub_word;
	logic [23:0] got;

	tb_clock_gen u_clk_gen (
		.clk_6m (clk_6m),
		.arst_n (arst_n)
	);

	cpu_subsystem uut (.*);

	bind cpu_subsystem cpu_subsystem_checker u_checker (.*);

	////////////////////////////////////////////////////////////
	// Reference address maps giving a region code or -1 for local space
	////////////////////////////////////////////////////////////

	function automatic int main_map(cpu_addr_t a);
		case (a[15:13])
			3'd0: return REGION_SCROLL0;
			3'd1: return REGION_SCROLL1;
			3'd2: return REGION_OBJECT;
			3'd4: begin
				case (a[12:9])
					4'd0: return REGION_LATCH0;
					4'd1: return REGION_LATCH1;
					4'd2: return REGION_BACKCOLOR;
					default: return -1;
				endcase
			end
			default: return -1;
		endcase
	endfunction

	function automatic int sub_map(cpu_addr_t a);
		case (a[15:13])
			3'd0: return REGION_OBJECT;
			3'd1: return REGION_SCROLL0;
			3'd2: return REGION_SCROLL1;
			3'd3: begin
				case (a[12:9])
					4'd0: return REGION_LATCH0;
					4'd1: return REGION_LATCH1;
					default: return -1;
				endcase
			end
			default: return -1;
		endcase
	endfunction

	// Windows 0 to 2 are 8K wide and the latch windows 512 bytes
	function automatic cpu_addr_t window_addr(logic to_sub, int idx, logic [12:0] off);
		cpu_addr_t base;
		if (idx < 3) begin
			return {idx[2:0], off};
		end
		base = to_sub ? 16'h6000 : 16'h8000;
		return base | cpu_addr_t'((idx - 3) << 9) | {7'd0, off[8:0]};
	endfunction

	function automatic logic system_idle();
		return main_todo.size() == 0 && sub_todo.size() == 0 &&
			main_exp.size() == 0 && sub_exp.size() == 0 &&
			main_cnt == `CPU_CREDITS && sub_cnt == `CPU_CREDITS &&
			ds_owed == 0 && !vbus_valid;
	endfunction

	task automatic send_write(input logic to_sub, input cpu_addr_t a, input cpu_data_t d);
		int r;
		r = to_sub ? sub_map(a) : main_map(a);
		if (to_sub) begin
			sub_todo.push_back({a, d});
			if (r >= 0) begin
				sub_exp.push_back({r[2:0], a[12:0], d});
			end
		end else begin
			main_todo.push_back({a, d});
			if (r >= 0) begin
				main_exp.push_back({r[2:0], a[12:0], d});
			end
		end
	endtask

	task automatic send_mapped(input logic to_sub, input int count);
		int          n;
		int          idx;
		logic [12:0] off;
		cpu_data_t   d;
		for (n = 0; n < count; n++) begin
			idx = $unsigned($random(seed)) % (to_sub ? 5 : 6);
			off = $random(seed);
			d = $random(seed);
			send_write(to_sub, window_addr(to_sub, idx, off), d);
		end
	endtask

	// Any address with a good share of them local
	task automatic send_random(input logic to_sub, input int count);
		int        n;
		cpu_addr_t a;
		cpu_data_t d;
		for (n = 0; n < count; n++) begin
			a = $random(seed);
			d = $random(seed);
			send_write(to_sub, a, d);
		end
	endtask

	task automatic wait_idle(input string name, input int limit);
		int n;
		n = 0;
		while (!system_idle() && n < limit) begin
			@(negedge clk_6m);
			n++;
		end
		if (!system_idle()) begin
			timeouts++;
			$display("Timeout: %s still had writes or credits outstanding after %0d cycles",
				name, limit);
		end
	endtask

	task automatic compare_write(input string who, input logic [23:0] seen,
			input logic [23:0] want);
		checked++;
		if (seen !== want) begin
			errors++;
			$display("ERR %0t: %s write got %h, expected %h", $time, who, seen, want);
		end
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("Test %0d %s finished, %0d writes checked, %0d errors so far",
			tests_done, name, checked, errors + timeouts);
	endtask

	////////////////////////////////////////////////////////////
	// CPU models, video side model and bus monitor
	////////////////////////////////////////////////////////////

	always @(posedge clk_6m) begin
		if (!arst_n) begin
			main_cnt = `CPU_CREDITS;
			main_valid <= 1'b0;
		end else begin
			main_cnt = main_cnt + int'(main_credit);
			if (main_todo.size() != 0 && main_cnt > 0) begin
				main_word = main_todo.pop_front();
				main_addr <= main_word[23:8];
				main_data <= main_word[7:0];
				main_valid <= 1'b1;
				main_cnt = main_cnt - 1;
			end else begin
				main_valid <= 1'b0;
			end
		end
	end

	always @(posedge clk_6m) begin
		if (!arst_n) begin
			sub_cnt = `CPU_CREDITS;
			sub_valid <= 1'b0;
		end else begin
			sub_cnt = sub_cnt + int'(sub_credit);
			if (sub_todo.size() != 0 && sub_cnt > 0) begin
				sub_word = sub_todo.pop_front();
				sub_addr <= sub_word[23:8];
				sub_data <= sub_word[7:0];
				sub_valid <= 1'b1;
				sub_cnt = sub_cnt - 1;
			end else begin
				sub_valid <= 1'b0;
			end
		end
	end

	// Returns one credit per write after a random delay and none while stalled
	always @(posedge clk_6m) begin
		if (!arst_n) begin
			ds_owed = 0;
			vbus_credit <= 1'b0;
		end else begin
			ds_owed = ds_owed + int'(vbus_valid);
			if (ds_owed > 0 && !ds_stall && (ds_fast || ($random(seed) & 3) == 0)) begin
				ds_owed = ds_owed - 1;
				vbus_credit <= 1'b1;
			end else begin
				vbus_credit <= 1'b0;
			end
		end
	end

	always @(posedge clk_6m) begin
		if (arst_n && vbus_valid) begin
			got = {vbus_region, vbus_addr, vbus_data};
			issue_log.push_back(vbus_master);
			issue_time.push_back($time);
			if (vbus_master == 1'b0 && main_exp.size() != 0) begin
				compare_write("main", got, main_exp.pop_front());
			end else if (vbus_master == 1'b1 && sub_exp.size() != 0) begin
				compare_write("sub", got, sub_exp.pop_front());
			end else begin
				errors++;
				$display("ERR %0t: unexpected write %h from master %0d on the video bus",
					$time, got, vbus_master);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int n;
		int pairs;
		main_valid = 1'b0;
		main_addr = '0;
		main_data = '0;
		sub_valid = 1'b0;
		sub_addr = '0;
		sub_data = '0;
		vbus_credit = 1'b0;

		n = 0;
		while (arst_n !== 1'b1 && n < 20) begin
			@(negedge clk_6m);
			n++;
		end
		if (arst_n !== 1'b1) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		@(negedge clk_6m);
		finish_test("reset");

		send_mapped(1'b0, 40);
		wait_idle("main decoding", 2000);
		finish_test("main decoding");

		send_mapped(1'b1, 40);
		wait_idle("sub decoding", 2000);
		finish_test("sub decoding");

		// Drops land next to pops on both ports
		send_random(1'b0, 40);
		send_random(1'b1, 40);
		wait_idle("local drops", 2000);
		finish_test("local drops");

		ds_fast = 1'b1;
		issue_log.delete();
		send_mapped(1'b0, 16);
		send_mapped(1'b1, 16);
		wait_idle("alternation", 2000);
		for (n = 1; n < issue_log.size(); n++) begin
			if (issue_log[n] == issue_log[n-1]) begin
				errors++;
				$display("ERR %0t: issues %0d and %0d both from master %0d",
					$time, n - 1, n, issue_log[n]);
			end
		end
		issue_log.delete();
		issue_time.delete();
		send_mapped(1'b0, 12);
		wait_idle("single master", 2000);
		if (issue_log.size() != 12) begin
			errors++;
			$display("ERR %0t: %0d main issues seen, expected 12", $time, issue_log.size());
		end
		// Two buffered main writes go out one clock period apart
		pairs = 0;
		for (n = 1; n < issue_time.size(); n++) begin
			if (issue_time[n] - issue_time[n-1] == 100) begin
				pairs++;
			end
		end
		if (pairs == 0) begin
			errors++;
			$display("ERR %0t: main CPU never took the idle sub slot", $time);
		end
		ds_fast = 1'b0;
		finish_test("alternation");

		// Long stall so that buffers fill and both CPUs run out of credits
		ds_stall = 1'b1;
		send_mapped(1'b0, 10);
		send_mapped(1'b1, 10);
		repeat (80) @(negedge clk_6m);
		ds_stall = 1'b0;
		wait_idle("back-pressure", 2000);
		finish_test("back-pressure");

		$display("Tests %0d, writes checked %0d, scoreboard errors %0d, timeouts %0d, %s %0d",
			tests_done, checked, errors, timeouts, "assertion failures",
			uut.u_checker.fail_count);
		if (errors == 0 && timeouts == 0 && uut.u_checker.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* cpu_subsystem.f */
+incdir+.
cpu_bus_pkg.sv
cpu_bus_if.sv
main_decoder.sv
sub_decoder.sv
bus_arbiter.sv
cpu_subsystem.sv
tb_clock_gen.sv
cpu_subsystem_checker.sv
tb_cpu_subsystem.sv
